// File: hw/lc3b_settings.svh
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// Data and address word width
`define LC3B_WORD_W 16

// General purpose registers R0 to R7
`define LC3B_NUM_REGS 8

// First instruction fetched after reset
`define LC3B_RESET_PC 16'h0000

`endif

// File: hw/lc3b_types.sv
`include "lc3b_settings.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

	// LC-3b opcode field, IR[15:12]
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_aluop;

	// One instruction at a time, phases in this order
	typedef enum logic [2:0] {s_fetch, s_decode, s_exec, s_mem, s_wb} seq_state;

	// Mux selects, zero is the default leg
	typedef enum logic [1:0] {alumux_reg, alumux_imm5, alumux_off6} lc3b_alumux;
	typedef enum logic [1:0] {rfmux_alu, rfmux_mem, rfmux_pctgt} lc3b_regfilemux;
	typedef enum logic [1:0] {pcmux_inc, pcmux_br, pcmux_base} lc3b_pcmux;

	typedef struct packed {
		lc3b_opcode opcode;
		logic load_cc;
		logic load_regfile;
		logic load_pc;
		lc3b_alumux alumux_sel;
		lc3b_regfilemux regfilemux_sel;
		lc3b_pcmux pcmux_sel;
		lc3b_aluop alu_op;
		logic mem_read;
		logic mem_write;
	} lc3b_control_word;

	// Read and write are levels held until the response pulse
	typedef struct packed {
		logic read;
		logic write;
		lc3b_word addr;
		lc3b_word wdata;
	} mem_req_t;

	typedef struct packed {
		lc3b_word pc;
		logic wb_en;
		lc3b_reg wb_reg;
		lc3b_word wb_data;
	} retire_t;

endpackage : lc3b_types

// File: hw/control_rom.sv
module control_rom (
	input lc3b_types::lc3b_word inst,
	output lc3b_types::lc3b_control_word ctrl
);

	import lc3b_types::*;

	lc3b_opcode opcode;

	assign opcode = lc3b_opcode'(inst[15:12]);

	always_comb begin
		// Defaults, a no-op that touches nothing
		ctrl.opcode = opcode;
		ctrl.load_cc = 1'b0;
		ctrl.load_regfile = 1'b0;
		ctrl.load_pc = 1'b0;
		ctrl.alumux_sel = alumux_reg;
		ctrl.regfilemux_sel = rfmux_alu;
		ctrl.pcmux_sel = pcmux_inc;
		ctrl.alu_op = alu_add;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;

		case (opcode)
			// DR <= SR1 + SR2 or imm5
			op_add: begin
				ctrl.alu_op = alu_add;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				if (inst[5])
					ctrl.alumux_sel = alumux_imm5;
			end

			op_and: begin
				ctrl.alu_op = alu_and;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				if (inst[5])
					ctrl.alumux_sel = alumux_imm5;
			end

			// Only SR at [8:6] matters
			op_not: begin
				ctrl.alu_op = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			// Address from ALU, data from memory into DR
			op_ldr: begin
				ctrl.alumux_sel = alumux_off6;
				ctrl.alu_op = alu_add;
				ctrl.mem_read = 1'b1;
				ctrl.regfilemux_sel = rfmux_mem;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			// Same address path, SR at [11:9] goes out as write data
			op_str: begin
				ctrl.alumux_sel = alumux_off6;
				ctrl.alu_op = alu_add;
				ctrl.mem_write = 1'b1;
			end

			// Taken or not is decided against CC in the datapath
			op_br: begin
				ctrl.pcmux_sel = pcmux_br;
				ctrl.load_pc = 1'b1;
			end

			op_jmp: begin
				ctrl.pcmux_sel = pcmux_base;
				ctrl.load_pc = 1'b1;
			end

			// DR <= PC+2 plus offset9 times two
			op_lea: begin
				ctrl.regfilemux_sel = rfmux_pctgt;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			// Recognized but not executed by this core
			op_shf, op_ldb, op_stb, op_jsr, op_trap, op_rti, op_ldi, op_sti: begin
				ctrl = '0;
			end

			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule : control_rom

// File: hw/fetch_unit.sv
`include "lc3b_settings.svh"

module fetch_unit (
	input logic clk,
	input logic rst,
	input logic fetch_start,
	input logic fetch_resp,
	input lc3b_types::lc3b_word mem_rdata,
	input logic load_pc,
	input lc3b_types::lc3b_word pc_next,
	output lc3b_types::mem_req_t fetch_req,
	output lc3b_types::lc3b_word pc,
	output lc3b_types::lc3b_word ir
);

	import lc3b_types::*;

	// Read outstanding after the start strobe
	logic pending_q;

	// Request is live in the strobe cycle itself
	assign fetch_req.read = fetch_start | pending_q;
	assign fetch_req.write = 1'b0;
	assign fetch_req.addr = pc;
	assign fetch_req.wdata = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending_q <= 1'b0;
			pc <= `LC3B_RESET_PC;
		end else begin
			if (fetch_resp)
				pending_q <= 1'b0;
			else if (fetch_start)
				pending_q <= 1'b1;

			// PC+2 on arrival, redirect at writeback
			if (fetch_resp)
				pc <= pc + lc3b_word'(2);
			else if (load_pc)
				pc <= pc_next;
		end
	end

	// IR holds until the next fetch returns
	always_ff @(posedge clk) begin
		if (fetch_resp)
			ir <= mem_rdata;
	end

endmodule : fetch_unit

// File: hw/datapath.sv
`include "lc3b_settings.svh"

module datapath (
	input logic clk,
	input logic rst,
	input lc3b_types::lc3b_control_word ctrl,
	input lc3b_types::lc3b_word ir,
	input lc3b_types::lc3b_word pc,
	input logic exec_en,
	input logic mem_start,
	input logic wb_en,
	input logic data_resp,
	input lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::mem_req_t data_req,
	output logic load_pc,
	output lc3b_types::lc3b_word pc_next,
	output lc3b_types::retire_t retire
);

	import lc3b_types::*;

	lc3b_word regs [`LC3B_NUM_REGS];
	logic [2:0] cc;
	lc3b_reg dr;
	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_word sr1_val;
	lc3b_word sr2_val;
	lc3b_word imm5_sext;
	lc3b_word off6_addr;
	lc3b_word off9_addr;
	lc3b_word alu_b;
	lc3b_word alu_result;
	lc3b_word alu_out_q;
	lc3b_word mdr_q;
	lc3b_word pc_target;
	lc3b_word wb_data;
	logic data_pend_q;
	logic data_active;
	logic br_taken;

	// Register fields, DR doubles as SR for STR and nzp for BR
	assign dr = ir[11:9];
	assign sr1 = ir[8:6];
	assign sr2 = ir[2:0];
	assign sr1_val = regs[sr1];
	assign sr2_val = regs[sr2];

	// Offsets are word offsets, so shift left once
	assign imm5_sext = lc3b_word'(signed'(ir[4:0]));
	assign off6_addr = lc3b_word'(signed'(ir[5:0])) << 1;
	assign off9_addr = lc3b_word'(signed'(ir[8:0])) << 1;

	// pc already points past this instruction
	assign pc_target = pc + off9_addr;

	always_comb begin
		case (ctrl.alumux_sel)
			alumux_imm5: alu_b = imm5_sext;
			alumux_off6: alu_b = off6_addr;
			default: alu_b = sr2_val;
		endcase

		case (ctrl.alu_op)
			alu_and: alu_result = sr1_val & alu_b;
			alu_not: alu_result = ~sr1_val;
			alu_pass: alu_result = alu_b;
			default: alu_result = sr1_val + alu_b;
		endcase

		case (ctrl.regfilemux_sel)
			rfmux_mem: wb_data = mdr_q;
			rfmux_pctgt: wb_data = pc_target;
			default: wb_data = alu_out_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (exec_en)
			alu_out_q <= alu_result;
		if (data_resp)
			mdr_q <= mem_rdata;
	end

	// Data access held from mem_start until its response
	always_ff @(posedge clk) begin
		if (rst)
			data_pend_q <= 1'b0;
		else if (data_resp)
			data_pend_q <= 1'b0;
		else if (mem_start)
			data_pend_q <= 1'b1;
	end

	assign data_active = mem_start | data_pend_q;
	assign data_req.read = data_active & ctrl.mem_read;
	assign data_req.write = data_active & ctrl.mem_write;
	assign data_req.addr = alu_out_q;
	assign data_req.wdata = regs[dr];

	// Writeback and NZP from the written value
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++)
				regs[i] <= '0;
			cc <= 3'b010;
		end else if (wb_en) begin
			if (ctrl.load_regfile)
				regs[dr] <= wb_data;
			if (ctrl.load_cc)
				cc <= {wb_data[`LC3B_WORD_W-1], wb_data == '0,
					!wb_data[`LC3B_WORD_W-1] && wb_data != '0};
		end
	end

	// Branch test against instruction nzp
	assign br_taken = |(ir[11:9] & cc);
	assign load_pc = wb_en & ctrl.load_pc & ((ctrl.pcmux_sel == pcmux_base) |
		((ctrl.pcmux_sel == pcmux_br) & br_taken));
	assign pc_next = (ctrl.pcmux_sel == pcmux_base) ? sr1_val : pc_target;

	assign retire.pc = pc - lc3b_word'(2);
	assign retire.wb_en = ctrl.load_regfile;
	assign retire.wb_reg = ctrl.load_regfile ? dr : '0;
	assign retire.wb_data = ctrl.load_regfile ? wb_data : '0;

endmodule : datapath

// File: hw/instr_sequencer.sv
module instr_sequencer (
	input logic clk,
	input logic rst,
	input lc3b_types::lc3b_control_word ctrl,
	input logic fetch_resp,
	input logic data_resp,
	output logic fetch_start,
	output logic exec_en,
	output logic mem_start,
	output logic wb_en,
	output logic retire_valid
);

	import lc3b_types::*;

	seq_state state;
	// Low only in the first cycle out of reset
	logic booted;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_fetch;
			booted <= 1'b0;
			fetch_start <= 1'b0;
			mem_start <= 1'b0;
		end else begin
			booted <= 1'b1;
			// Start strobes are single cycle
			fetch_start <= !booted;
			mem_start <= 1'b0;
			case (state)
				s_fetch: begin
					if (fetch_resp)
						state <= s_decode;
				end
				s_decode: state <= s_exec;
				s_exec: begin
					// No data access means straight to writeback
					if (ctrl.mem_read | ctrl.mem_write) begin
						state <= s_mem;
						mem_start <= 1'b1;
					end else begin
						state <= s_wb;
					end
				end
				s_mem: begin
					if (data_resp)
						state <= s_wb;
				end
				s_wb: begin
					state <= s_fetch;
					fetch_start <= 1'b1;
				end
				default: state <= s_fetch;
			endcase
		end
	end

	assign exec_en = (state == s_exec);
	assign wb_en = (state == s_wb);
	assign retire_valid = (state == s_wb);

endmodule : instr_sequencer

// File: hw/mem_arbiter.sv
module mem_arbiter (
	input logic clk,
	input logic rst,
	input lc3b_types::mem_req_t fetch_req,
	input lc3b_types::mem_req_t data_req,
	input logic mem_resp,
	output lc3b_types::mem_req_t mem_req,
	output logic fetch_resp,
	output logic data_resp
);

	logic fetch_active;
	logic data_active;
	// Grant held between first cycle and response
	logic busy_q;
	logic owner_data_q;
	logic sel_data;

	assign fetch_active = fetch_req.read | fetch_req.write;
	assign data_active = data_req.read | data_req.write;

	// Locked owner, else data wins a new tie
	assign sel_data = busy_q ? owner_data_q : data_active;

	// Pass through in the first cycle
	assign mem_req = sel_data ? data_req : fetch_req;

	// Response goes only to the granted side
	assign fetch_resp = mem_resp & !sel_data;
	assign data_resp = mem_resp & sel_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			owner_data_q <= 1'b0;
		end else if (mem_resp) begin
			busy_q <= 1'b0;
		end else if (!busy_q && (fetch_active || data_active)) begin
			busy_q <= 1'b1;
			owner_data_q <= data_active;
		end
	end

endmodule : mem_arbiter

// File: hw/lc3b_core.sv
module lc3b_core (
	input logic clk,
	input logic rst,
	output lc3b_types::mem_req_t mem_req,
	input lc3b_types::lc3b_word mem_rdata,
	input logic mem_resp,
	output lc3b_types::retire_t retire,
	output logic retire_valid
);

	import lc3b_types::*;

	lc3b_control_word ctrl;
	mem_req_t fetch_req;
	mem_req_t data_req;
	lc3b_word pc;
	lc3b_word ir;
	lc3b_word pc_next;
	logic load_pc;
	logic fetch_resp;
	logic data_resp;
	logic fetch_start;
	logic exec_en;
	logic mem_start;
	logic wb_en;

	fetch_unit fetch (.clk(clk), .rst(rst), .fetch_start(fetch_start),
		.fetch_resp(fetch_resp), .mem_rdata(mem_rdata), .load_pc(load_pc),
		.pc_next(pc_next), .fetch_req(fetch_req), .pc(pc), .ir(ir));

	control_rom rom (.inst(ir), .ctrl(ctrl));

	datapath dp (.clk(clk), .rst(rst), .ctrl(ctrl), .ir(ir), .pc(pc),
		.exec_en(exec_en), .mem_start(mem_start), .wb_en(wb_en), .data_resp(data_resp),
		.mem_rdata(mem_rdata), .data_req(data_req), .load_pc(load_pc),
		.pc_next(pc_next), .retire(retire));

	instr_sequencer seq (.clk(clk), .rst(rst), .ctrl(ctrl), .fetch_resp(fetch_resp),
		.data_resp(data_resp), .fetch_start(fetch_start), .exec_en(exec_en),
		.mem_start(mem_start), .wb_en(wb_en), .retire_valid(retire_valid));

	mem_arbiter arb (.clk(clk), .rst(rst), .fetch_req(fetch_req), .data_req(data_req),
		.mem_resp(mem_resp), .mem_req(mem_req), .fetch_resp(fetch_resp),
		.data_resp(data_resp));

endmodule : lc3b_core

// File: test/lc3b_core_props.sv
module lc3b_core_props (
	input logic clk,
	input logic rst,
	input lc3b_types::mem_req_t fetch_req,
	input lc3b_types::mem_req_t data_req,
	input lc3b_types::mem_req_t mem_req,
	input logic mem_resp,
	input logic fetch_resp,
	input logic data_resp,
	input logic busy_q,
	input logic owner_data_q
);

	// Strobes are exclusive
	no_read_write: assert property (@(posedge clk) disable iff (rst)
		!(mem_req.read && mem_req.write))
		else $error("memory read and write strobes high together");

	// Waiting request keeps strobe, addr and wdata
	req_held: assert property (@(posedge clk) disable iff (rst)
		(mem_req.read || mem_req.write) && !mem_resp |=> $stable(mem_req))
		else $error("memory request changed before its response");

	// Only one side is asking when a locked grant gets its response
	resp_one_side: assert property (@(posedge clk) disable iff (rst)
		mem_resp |-> busy_q && (fetch_req.read != (data_req.read || data_req.write)))
		else $error("memory response with both or neither requester asking");

	// The owner is the side still asking
	resp_to_owner: assert property (@(posedge clk) disable iff (rst)
		mem_resp |-> (owner_data_q ? (data_resp && (data_req.read || data_req.write))
			: (fetch_resp && fetch_req.read)))
		else $error("memory response went to a requester without the grant");

endmodule : lc3b_core_props

bind mem_arbiter lc3b_core_props props (.clk(clk), .rst(rst), .fetch_req(fetch_req),
	.data_req(data_req), .mem_req(mem_req), .mem_resp(mem_resp), .fetch_resp(fetch_resp),
	.data_resp(data_resp), .busy_q(busy_q), .owner_data_q(owner_data_q));

// File: test/lc3b_core_tb.sv
`include "lc3b_settings.svh"

module lc3b_core_tb;

	import lc3b_types::*;

	localparam int prog_len = 31;
	localparam int num_rows = 21;
	localparam int num_stores = 2;
	localparam int mem_words = 2 ** (`LC3B_WORD_W - 1);
	localparam int timeout_cycles = num_rows * 20;

	// Program image loaded from address zero
	localparam lc3b_word prog [prog_len] = '{
		16'h1265, // 00 ADD R1, R1, #5
		16'h147D, // 02 ADD R2, R1, #-3
		16'h1642, // 04 ADD R3, R1, R2
		16'h58E6, // 06 AND R4, R3, #6
		16'h5AC2, // 08 AND R5, R3, R2
		16'h9CFF, // 0A NOT R6, R3
		16'h0801, // 0C BRn to 10
		16'h1FE1, // 0E skipped
		16'h0601, // 10 BRzp not taken
		16'h769F, // 12 STR R3, R2, #31
		16'h6E9F, // 14 LDR R7, R2, #31
		16'h7C9E, // 16 STR R6, R2, #30
		16'h629E, // 18 LDR R1, R2, #30
		16'h5020, // 1A AND R0, R0, #0
		16'h0402, // 1C BRz to 22
		16'h1FE1, 16'h1FE1,
		16'hE808, // 22 LEA R4, #8
		16'hC100, // 24 JMP R4
		16'h1FE1, 16'h1FE1, 16'h1FE1, 16'h1FE1, 16'h1FE1, 16'h1FE1, 16'h1FE1,
		16'hD241, // 34 SHF as a no-op
		16'hF025, // 36 TRAP x25 as a no-op
		16'hA123, // 38 reserved opcode
		16'h1A47, // 3A ADD R5, R1, R7
		16'h03E2  // 3C BRp backward not taken
	};

	// Retire rows in program order with fields as in retire_t
	localparam retire_t exp_retire [num_rows] = '{
		{16'h0000, 1'b1, 3'd1, 16'h0005},
		{16'h0002, 1'b1, 3'd2, 16'h0002},
		{16'h0004, 1'b1, 3'd3, 16'h0007},
		{16'h0006, 1'b1, 3'd4, 16'h0006},
		{16'h0008, 1'b1, 3'd5, 16'h0002},
		{16'h000A, 1'b1, 3'd6, 16'hFFF8},
		{16'h000C, 1'b0, 3'd0, 16'h0000},
		{16'h0010, 1'b0, 3'd0, 16'h0000},
		{16'h0012, 1'b0, 3'd0, 16'h0000},
		{16'h0014, 1'b1, 3'd7, 16'h0007},
		{16'h0016, 1'b0, 3'd0, 16'h0000},
		{16'h0018, 1'b1, 3'd1, 16'hFFF8},
		{16'h001A, 1'b1, 3'd0, 16'h0000},
		{16'h001C, 1'b0, 3'd0, 16'h0000},
		{16'h0022, 1'b1, 3'd4, 16'h0034},
		{16'h0024, 1'b0, 3'd0, 16'h0000},
		{16'h0034, 1'b0, 3'd0, 16'h0000},
		{16'h0036, 1'b0, 3'd0, 16'h0000},
		{16'h0038, 1'b0, 3'd0, 16'h0000},
		{16'h003A, 1'b1, 3'd5, 16'hFFFF},
		{16'h003C, 1'b0, 3'd0, 16'h0000}
	};

	// Writes expected at the memory port with fields as in mem_req_t
	localparam mem_req_t exp_store [num_stores] = '{
		{1'b0, 1'b1, 16'h0040, 16'h0007},
		{1'b0, 1'b1, 16'h003E, 16'hFFF8}
	};

	logic clk = 1'b0;
	logic rst = 1'b1;
	mem_req_t mem_req;
	lc3b_word mem_rdata = '0;
	logic mem_resp = 1'b0;
	retire_t retire;
	logic retire_valid;

	// Memory model state
	lc3b_word mem [mem_words];
	logic [19:0] lfsr;
	logic [1:0] delay;
	logic [1:0] wait_cnt;
	logic busy;
	int store_idx = 0;
	int store_pass = 0;
	int store_fail = 0;
	int retire_pass = 0;
	int retire_fail = 0;

	lc3b_core uut (.clk(clk), .rst(rst), .mem_req(mem_req), .mem_rdata(mem_rdata),
		.mem_resp(mem_resp), .retire(retire), .retire_valid(retire_valid));

	initial begin
		forever #2 clk = ~clk;
	end

	// 20-bit Fibonacci LFSR with taps 20 and 17
	function automatic logic [19:0] lfsr_next(input logic [19:0] s);
		return {s[18:0], s[19] ^ s[16]};
	endfunction

	task automatic check_retire(input int idx, input retire_t got, input retire_t exp);
		if (got === exp) begin
			retire_pass++;
			$display("PASS retire %0d pc=%h", idx, got.pc);
		end else begin
			retire_fail++;
			$display("FAIL retire %0d: retire got %h expected %h", idx, got, exp);
		end
	endtask

	task automatic check_store(input int idx, input mem_req_t got, input mem_req_t exp);
		if (got === exp) begin
			store_pass++;
			$display("PASS store %0d addr=%h data=%h", idx, got.addr, got.wdata);
		end else begin
			store_fail++;
			$display("FAIL store %0d: mem_req got %h expected %h", idx, got, exp);
		end
	endtask

	task automatic report_and_finish(input int extra_fail);
		int passed;
		int failed;
		passed = retire_pass + store_pass;
		failed = retire_fail + store_fail + extra_fail;
		$display("Checks: %0d passed, %0d failed", passed, failed);
		if (failed == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	// One request at a time answered 1 to 4 cycles after it is seen
	always @(posedge clk) begin
		if (rst) begin
			mem_resp <= 1'b0;
			mem_rdata <= '0;
			busy = 1'b0;
			wait_cnt = 2'd0;
			lfsr = 20'd96500;
			store_idx = 0;
			for (int i = 0; i < mem_words; i++)
				mem[i] = lc3b_word'(i) ^ 16'hC3A5;
			for (int i = 0; i < prog_len; i++)
				mem[i] = prog[i];
		end else begin
			mem_resp <= 1'b0;
			if (busy) begin
				if (wait_cnt == 2'd0) begin
					busy = 1'b0;
					mem_resp <= 1'b1;
					if (mem_req.write) begin
						mem[mem_req.addr[`LC3B_WORD_W-1:1]] = mem_req.wdata;
						if (store_idx < num_stores) begin
							check_store(store_idx, mem_req, exp_store[store_idx]);
						end else begin
							store_fail++;
							$display("Unexpected memory write to address %h", mem_req.addr);
						end
						store_idx++;
					end else begin
						mem_rdata <= mem[mem_req.addr[`LC3B_WORD_W-1:1]];
					end
				end else begin
					wait_cnt = wait_cnt - 2'd1;
				end
			end else if ((mem_req.read || mem_req.write) && !mem_resp) begin
				// Two LFSR bits pick the latency
				busy = 1'b1;
				lfsr = lfsr_next(lfsr);
				delay[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				delay[1] = lfsr[0];
				wait_cnt = delay;
			end
		end
	end

	initial begin
		int row;
		int extra;
		extra = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		// Retire is sampled mid-cycle
		for (row = 0; row < num_rows; row++) begin
			@(negedge clk);
			while (!retire_valid)
				@(negedge clk);
			check_retire(row, retire, exp_retire[row]);
		end
		if (store_idx != num_stores) begin
			$display("Only %0d of %0d expected memory writes were seen", store_idx, num_stores);
			extra = 1;
		end
		report_and_finish(extra);
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run timed out after %0d cycles before every instruction retired", cycles);
		report_and_finish(1);
	end

endmodule : lc3b_core_tb

// File: project.f
+incdir+hw
hw/lc3b_types.sv
hw/control_rom.sv
hw/fetch_unit.sv
hw/datapath.sv
hw/instr_sequencer.sv
hw/mem_arbiter.sv
hw/lc3b_core.sv
test/lc3b_core_props.sv
test/lc3b_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LC-3b core testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module lc3b_core_tb \
	-f project.f -Mdir obj_dir -o lc3b_core_sim \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/lc3b_core_sim > "$LOG" 2>&1
cat "$LOG"

grep -qx "Test passed" "$LOG" && echo "Simulation PASSED" \
	|| { echo "Simulation FAILED, see $LOG"; exit 1; }
